/* common/memBusPkg.sv */
`default_nettype none

package memBusPkg;

    // Byte address as seen by the core. The controller keeps only the low
    // bits that reach the RAM.
    typedef logic [31:0] addrT;

    // One data word, little-endian in memory.
    typedef logic [31:0] dataT;

    // Access length in bytes. Only 1, 2 and 4 are used.
    typedef logic [2:0] lenT;

    // Hold-off vector from the controller. Bit 0 belongs to the fetch port
    // and bit 1 to the data port.
    typedef logic [1:0] waitT;

    // Which port the controller is serving.
    typedef enum logic {
        portFetch,
        portData
    } portIdxT;

    // Fetches always move a whole word.
    localparam lenT wordLen = 3'd4;

endpackage

`default_nettype wire

/* common/lsuPkg.sv */
`default_nettype none

package lsuPkg;

    // Tag of a store/load buffer entry, returned with the response so the
    // buffer can match it to the waiting slot.
    typedef logic [3:0] nickT;

    // Direction of a data access.
    typedef enum logic {
        accLoad,
        accStore
    } accessT;

endpackage

`default_nettype wire

/* fetch/fetchPort.sv */
`timescale 1ns/1ps
`default_nettype none

module fetchPort (
    input  logic            clk,
    input  logic            rst,
    input  logic            rdy,
    input  logic            fetchEn,
    input  memBusPkg::addrT fetchAddr,
    input  logic            memWait,
    input  logic            memDone,
    input  memBusPkg::dataT memData,
    output logic            fetchReady,
    output logic            fetchDone,
    output memBusPkg::dataT fetchData,
    output logic            reqEn,
    output memBusPkg::addrT reqAddr
);

    logic occupied;

    assign fetchReady = rdy && !occupied;

    always_ff @(posedge clk) begin
        if (rst) begin
            occupied  <= 1'b0;
            reqEn     <= 1'b0;
            fetchDone <= 1'b0;
        end else if (rdy) begin
            fetchDone <= memDone;
            if (memDone) begin
                occupied <= 1'b0;
            end else if (fetchEn && !occupied) begin
                occupied <= 1'b1;
            end
            // Drop the request on the done cycle so the controller,
            // which is idle again by then, does not serve it twice.
            reqEn <= occupied && !memWait && !memDone;
        end
    end

    always_ff @(posedge clk) begin
        if (rdy) begin
            if (fetchEn && !occupied) begin
                reqAddr <= fetchAddr;
            end
            if (memDone) begin
                fetchData <= memData;
            end
        end
    end

endmodule

`default_nettype wire

/* data/dataPort.sv */
`timescale 1ns/1ps
`default_nettype none

module dataPort (
    input  logic            clk,
    input  logic            rst,
    input  logic            rdy,
    input  logic            lsuEn,
    input  lsuPkg::accessT  lsuAccess,
    input  memBusPkg::addrT lsuAddr,
    input  memBusPkg::dataT lsuData,
    input  memBusPkg::lenT  lsuLen,
    input  lsuPkg::nickT    lsuNick,
    input  logic            memWait,
    input  logic            memDone,
    input  memBusPkg::dataT memData,
    output logic            lsuReady,
    output logic            lsuDone,
    output memBusPkg::dataT rdData,
    output lsuPkg::nickT    respNick,
    output logic            reqEn,
    output logic            reqWrite,
    output memBusPkg::addrT reqAddr,
    output memBusPkg::dataT reqData,
    output memBusPkg::lenT  reqLen
);
    import lsuPkg::*;

    logic occupied;
    nickT nick;
    logic capture;

    assign lsuReady = rdy && !occupied;
    assign capture  = lsuEn && !occupied;

    always_ff @(posedge clk) begin
        if (rst) begin
            occupied <= 1'b0;
            reqEn    <= 1'b0;
            lsuDone  <= 1'b0;
        end else if (rdy) begin
            lsuDone <= memDone;
            if (memDone) begin
                occupied <= 1'b0;
            end else if (capture) begin
                occupied <= 1'b1;
            end
            // While the controller serves another port the wait bit stays
            // low, so the request keeps being offered until it is taken.
            reqEn <= occupied && !memWait && !memDone;
        end
    end

    // The captured fields drive the controller directly.
    always_ff @(posedge clk) begin
        if (rdy) begin
            if (capture) begin
                reqWrite <= (lsuAccess == accStore);
                reqAddr  <= lsuAddr;
                reqData  <= lsuData;
                reqLen   <= lsuLen;
                nick     <= lsuNick;
            end
            if (memDone) begin
                rdData   <= memData;
                respNick <= nick;
            end
        end
    end

endmodule

`default_nettype wire

/* memctrl/byteRam.sv */
`timescale 1ns/1ps
`default_nettype none

module byteRam #(
    parameter int ramAddrBits = 12
) (
    input  logic                   clk,
    input  logic                   en,
    input  logic                   we,
    input  logic [ramAddrBits-1:0] addr,
    input  logic [7:0]             wdata,
    output logic [7:0]             rdata
);

    localparam int depth = 2 ** ramAddrBits;

    logic [7:0] mem [depth];

    initial begin
        for (int i = 0; i < depth; i++) begin
            mem[i] = 8'h00;
        end
    end

    // The read register only changes on a read, so it keeps its byte while
    // the controller is stalled.
    always_ff @(posedge clk) begin
        if (en) begin
            if (we) begin
                mem[addr] <= wdata;
            end else begin
                rdata <= mem[addr];
            end
        end
    end

endmodule

`default_nettype wire

/* memctrl/memController.sv */
`timescale 1ns/1ps
`default_nettype none

module memController #(
    parameter int ramAddrBits = 12
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   rdy,
    input  logic                   fReqEn,
    input  memBusPkg::addrT        fReqAddr,
    input  logic                   dReqEn,
    input  logic                   dReqWrite,
    input  memBusPkg::addrT        dReqAddr,
    input  memBusPkg::dataT        dReqData,
    input  memBusPkg::lenT         dReqLen,
    input  logic [7:0]             ramRdata,
    output memBusPkg::waitT        memWait,
    output logic                   fMemDone,
    output logic                   dMemDone,
    output memBusPkg::dataT        memData,
    output logic                   ramEn,
    output logic                   ramWe,
    output logic [ramAddrBits-1:0] ramAddr,
    output logic [7:0]             ramWdata
);
    import memBusPkg::*;

    typedef enum logic [1:0] {
        idle,
        transfer,
        finish
    } stateT;

    stateT                  state;
    portIdxT                grant;
    logic [ramAddrBits-1:0] baseAddr;
    lenT                    curLen;
    lenT                    byteCnt;
    logic                   isWrite;
    dataT                   shiftData;
    dataT                   word;
    dataT                   assembled;
    logic                   pendRead;
    logic [1:0]             pendIdx;
    logic                   accept;
    logic                   lastByte;

    // The data port has priority over the fetch port.
    assign accept   = (state == idle) && (dReqEn || fReqEn);
    assign lastByte = (byteCnt == lenT'(curLen - 3'd1));

    // The RAM is only touched on live cycles, so a stall leaves its read
    // register holding the byte that is still pending.
    assign ramEn    = (state == transfer) && rdy;
    assign ramWe    = ramEn && isWrite;
    assign ramAddr  = baseAddr + ramAddrBits'(byteCnt);
    assign ramWdata = shiftData[7:0];

    // A read issued last cycle lands in its byte lane of the word.
    always_comb begin
        assembled = word;
        if (pendRead) begin
            assembled[{pendIdx, 3'b000} +: 8] = ramRdata;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= idle;
            memWait  <= '0;
            fMemDone <= 1'b0;
            dMemDone <= 1'b0;
            pendRead <= 1'b0;
            byteCnt  <= '0;
        end else if (rdy) begin
            fMemDone <= 1'b0;
            dMemDone <= 1'b0;
            pendRead <= 1'b0;
            case (state)
                idle: begin
                    if (accept) begin
                        state   <= transfer;
                        byteCnt <= '0;
                        memWait <= dReqEn ? waitT'(2'b10) : waitT'(2'b01);
                    end
                end
                transfer: begin
                    pendRead <= !isWrite;
                    byteCnt  <= byteCnt + 3'd1;
                    if (lastByte) begin
                        state <= finish;
                    end
                end
                finish: begin
                    fMemDone <= (grant == portFetch);
                    dMemDone <= (grant == portData);
                    memWait  <= '0;
                    state    <= idle;
                end
                default: state <= idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rdy) begin
            if (accept) begin
                word <= '0;
                if (dReqEn) begin
                    grant     <= portData;
                    baseAddr  <= dReqAddr[ramAddrBits-1:0];
                    curLen    <= dReqLen;
                    isWrite   <= dReqWrite;
                    shiftData <= dReqData;
                end else begin
                    grant     <= portFetch;
                    baseAddr  <= fReqAddr[ramAddrBits-1:0];
                    curLen    <= wordLen;
                    isWrite   <= 1'b0;
                    shiftData <= '0;
                end
            end
            if (state == transfer) begin
                word      <= assembled;
                pendIdx   <= byteCnt[1:0];
                shiftData <= shiftData >> 8;
            end
            if (state == finish) begin
                memData <= assembled;
            end
        end
    end

endmodule

`default_nettype wire

/* logic/memSubsystem.sv */
`timescale 1ns/1ps
`default_nettype none

module memSubsystem #(
    parameter int ramAddrBits = 12
) (
    input  logic            clk,
    input  logic            rst,
    input  logic            rdy,
    input  logic            fetchEn,
    input  memBusPkg::addrT fetchAddr,
    output logic            fetchReady,
    output logic            fetchDone,
    output memBusPkg::dataT fetchData,
    input  logic            lsuEn,
    input  lsuPkg::accessT  lsuAccess,
    input  memBusPkg::addrT lsuAddr,
    input  memBusPkg::dataT lsuData,
    input  memBusPkg::lenT  lsuLen,
    input  lsuPkg::nickT    lsuNick,
    output logic            lsuReady,
    output logic            lsuDone,
    output memBusPkg::dataT rdData,
    output lsuPkg::nickT    respNick
);
    import memBusPkg::*;

    logic                   fReqEn;
    addrT                   fReqAddr;
    logic                   fMemDone;
    logic                   dReqEn;
    logic                   dReqWrite;
    addrT                   dReqAddr;
    dataT                   dReqData;
    lenT                    dReqLen;
    logic                   dMemDone;
    dataT                   memData;
    waitT                   memWait;
    logic                   ramEn;
    logic                   ramWe;
    logic [ramAddrBits-1:0] ramAddr;
    logic [7:0]             ramWdata;
    logic [7:0]             ramRdata;

    fetchPort fetch (
        .clk        (clk),
        .rst        (rst),
        .rdy        (rdy),
        .fetchEn    (fetchEn),
        .fetchAddr  (fetchAddr),
        .memWait    (memWait[0]),
        .memDone    (fMemDone),
        .memData    (memData),
        .fetchReady (fetchReady),
        .fetchDone  (fetchDone),
        .fetchData  (fetchData),
        .reqEn      (fReqEn),
        .reqAddr    (fReqAddr)
    );

    dataPort data (
        .clk       (clk),
        .rst       (rst),
        .rdy       (rdy),
        .lsuEn     (lsuEn),
        .lsuAccess (lsuAccess),
        .lsuAddr   (lsuAddr),
        .lsuData   (lsuData),
        .lsuLen    (lsuLen),
        .lsuNick   (lsuNick),
        .memWait   (memWait[1]),
        .memDone   (dMemDone),
        .memData   (memData),
        .lsuReady  (lsuReady),
        .lsuDone   (lsuDone),
        .rdData    (rdData),
        .respNick  (respNick),
        .reqEn     (dReqEn),
        .reqWrite  (dReqWrite),
        .reqAddr   (dReqAddr),
        .reqData   (dReqData),
        .reqLen    (dReqLen)
    );

    memController #(
        .ramAddrBits (ramAddrBits)
    ) ctrl (
        .clk       (clk),
        .rst       (rst),
        .rdy       (rdy),
        .fReqEn    (fReqEn),
        .fReqAddr  (fReqAddr),
        .dReqEn    (dReqEn),
        .dReqWrite (dReqWrite),
        .dReqAddr  (dReqAddr),
        .dReqData  (dReqData),
        .dReqLen   (dReqLen),
        .ramRdata  (ramRdata),
        .memWait   (memWait),
        .fMemDone  (fMemDone),
        .dMemDone  (dMemDone),
        .memData   (memData),
        .ramEn     (ramEn),
        .ramWe     (ramWe),
        .ramAddr   (ramAddr),
        .ramWdata  (ramWdata)
    );

    byteRam #(
        .ramAddrBits (ramAddrBits)
    ) ram (
        .clk   (clk),
        .en    (ramEn),
        .we    (ramWe),
        .addr  (ramAddr),
        .wdata (ramWdata),
        .rdata (ramRdata)
    );

endmodule

`default_nettype wire

/* test/memSubsystemTb.sv */
`timescale 1ns/1ps
`default_nettype none

module memSubsystemTb;
    import memBusPkg::*;
    import lsuPkg::*;

    localparam int ramAddrBits  = 12;
    localparam int ramBytes     = 2 ** ramAddrBits;
    localparam int resetCycles  = 8;
    localparam int rowBits      = 4;
    localparam int numRows      = 2 ** rowBits;
    localparam int cyclesPerRow = 20;

    typedef enum logic [1:0] {
        rowFetch,
        rowLoad,
        rowStore,
        rowBoth
    } kindT;

    logic    clk;
    logic    rst;
    logic    rdy;
    logic    fetchEn;
    addrT    fetchAddr;
    logic    fetchReady;
    logic    fetchDone;
    dataT    fetchData;
    logic    lsuEn;
    accessT  lsuAccess;
    addrT    lsuAddr;
    dataT    lsuData;
    lenT     lsuLen;
    nickT    lsuNick;
    logic    lsuReady;
    logic    lsuDone;
    dataT    rdData;
    nickT    respNick;

    // Stimulus table, one entry per row.
    kindT rowKind  [numRows];
    addrT rowAddr  [numRows];
    lenT  rowLen   [numRows];
    dataT rowData  [numRows];
    nickT rowNick  [numRows];
    int   rowStall [numRows];
    int   rowCount;

    logic [7:0]  refMem [ramBytes];
    logic [31:0] lfsrState;

    memSubsystem #(
        .ramAddrBits (ramAddrBits)
    ) uut (
        .clk        (clk),
        .rst        (rst),
        .rdy        (rdy),
        .fetchEn    (fetchEn),
        .fetchAddr  (fetchAddr),
        .fetchReady (fetchReady),
        .fetchDone  (fetchDone),
        .fetchData  (fetchData),
        .lsuEn      (lsuEn),
        .lsuAccess  (lsuAccess),
        .lsuAddr    (lsuAddr),
        .lsuData    (lsuData),
        .lsuLen     (lsuLen),
        .lsuNick    (lsuNick),
        .lsuReady   (lsuReady),
        .lsuDone    (lsuDone),
        .rdData     (rdData),
        .respNick   (respNick)
    );

    initial begin
        clk = 1'b0;
    end

    always #5 clk = ~clk;

    task automatic stopWithFailure(input string why);
        $display("%s", why);
        $display("Finished with errors");
        $fatal(1, "simulation stopped");
    endtask

    task automatic checkData(input string name, input dataT got, input dataT exp);
        if (got !== exp) begin
            stopWithFailure($sformatf("mismatch %s: got %h expected %h", name, got, exp));
        end
    endtask

    task automatic checkNick(input string name, input nickT got, input nickT exp);
        if (got !== exp) begin
            stopWithFailure($sformatf("mismatch %s: got %h expected %h", name, got, exp));
        end
    endtask

    task automatic checkReady(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            stopWithFailure($sformatf("mismatch %s: got %h expected %h", name, got, exp));
        end
    endtask

    // Fibonacci LFSR with taps 32, 22, 2 and 1.
    function automatic logic [31:0] lfsrNext(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic takeBits(input int count, output logic [31:0] value);
        value = '0;
        for (int i = 0; i < count; i++) begin
            lfsrState = lfsrNext(lfsrState);
            value     = {value[30:0], lfsrState[0]};
        end
    endtask

    // Little-endian and zero-extended, wrapping at the end of the RAM.
    function automatic dataT expectedWord(input addrT addr, input lenT len);
        dataT                   w;
        logic [ramAddrBits-1:0] idx;
        w = '0;
        for (int i = 0; i < int'(len); i++) begin
            idx = addr[ramAddrBits-1:0] + ramAddrBits'(i);
            w   = w | (dataT'(refMem[idx]) << (8 * i));
        end
        return w;
    endfunction

    task automatic storeRef(input addrT addr, input lenT len, input dataT data);
        logic [ramAddrBits-1:0] idx;
        for (int i = 0; i < int'(len); i++) begin
            idx         = addr[ramAddrBits-1:0] + ramAddrBits'(i);
            refMem[idx] = 8'(data >> (8 * i));
        end
    endtask

    task automatic addRow(input kindT kind, input addrT addr, input lenT len,
                          input nickT nick, input int stall);
        logic [31:0] bits;
        bits = '0;
        if (kind == rowStore) begin
            takeBits(32, bits);
        end
        rowKind[rowBits'(rowCount)]  = kind;
        rowAddr[rowBits'(rowCount)]  = addr;
        rowLen[rowBits'(rowCount)]   = len;
        rowData[rowBits'(rowCount)]  = bits;
        rowNick[rowBits'(rowCount)]  = nick;
        rowStall[rowBits'(rowCount)] = stall;
        rowCount++;
    endtask

    task automatic buildTable();
        logic [31:0] randAddr;
        rowCount = 0;
        addRow(rowLoad,  32'h0000_0100, 3'd4, 4'h1, 0);
        addRow(rowFetch, 32'hffff_f3f0, 3'd4, 4'h0, 0);
        addRow(rowStore, 32'h0000_0200, 3'd1, 4'h2, 0);
        addRow(rowLoad,  32'h0000_0200, 3'd4, 4'h3, 0);
        addRow(rowStore, 32'h0000_0201, 3'd2, 4'h4, 0);
        addRow(rowLoad,  32'h0000_0200, 3'd4, 4'h5, 0);
        addRow(rowStore, 32'h0000_0204, 3'd4, 4'h6, 0);
        addRow(rowLoad,  32'h0000_0204, 3'd4, 4'h7, 0);
        addRow(rowFetch, 32'h0000_0202, 3'd4, 4'h0, 0);
        addRow(rowLoad,  32'h0000_0205, 3'd2, 4'h8, 0);
        addRow(rowBoth,  32'h0000_0200, 3'd4, 4'h9, 0);
        addRow(rowLoad,  32'h0000_0204, 3'd1, 4'ha, 6);
        takeBits(ramAddrBits, randAddr);
        addRow(rowStore, randAddr, 3'd4, 4'hb, 4);
        addRow(rowBoth,  randAddr, 3'd4, 4'hc, 0);
        takeBits(ramAddrBits, randAddr);
        addRow(rowStore, randAddr, 3'd2, 4'hd, 0);
        addRow(rowFetch, randAddr, 3'd4, 4'h0, 0);
    endtask

    task automatic runRow(input logic [rowBits-1:0] r);
        kindT kind;
        dataT expLoad;
        dataT expFetch;
        logic wantFetch;
        logic wantLoad;
        logic gotFetch;
        logic gotLoad;
        logic rdyNow;
        int   cycle;
        int   fetchAt;
        int   loadAt;
        kind      = rowKind[r];
        wantFetch = (kind == rowFetch) || (kind == rowBoth);
        wantLoad  = (kind != rowFetch);
        expFetch  = expectedWord(rowAddr[r], 3'd4);
        expLoad   = expectedWord(rowAddr[r], rowLen[r]);
        if (kind == rowStore) begin
            storeRef(rowAddr[r], rowLen[r], rowData[r]);
        end

        @(posedge clk);
        if (wantFetch) begin
            fetchEn   <= 1'b1;
            fetchAddr <= rowAddr[r];
        end
        if (wantLoad) begin
            lsuEn     <= 1'b1;
            lsuAccess <= (kind == rowStore) ? accStore : accLoad;
            lsuAddr   <= rowAddr[r];
            lsuData   <= rowData[r];
            lsuLen    <= rowLen[r];
            lsuNick   <= rowNick[r];
        end
        @(posedge clk);
        fetchEn <= 1'b0;
        lsuEn   <= 1'b0;
        // The ports must work from their captured copies from here on.
        fetchAddr <= ~rowAddr[r];
        lsuAddr   <= ~rowAddr[r];
        lsuData   <= ~rowData[r];
        lsuNick   <= ~rowNick[r];

        gotFetch = !wantFetch;
        gotLoad  = !wantLoad;
        cycle    = 0;
        fetchAt  = 0;
        loadAt   = 0;
        while (!(gotFetch && gotLoad)) begin
            @(posedge clk);
            cycle++;
            rdyNow = rdy;
            if (!rdyNow && (lsuDone || fetchDone)) begin
                stopWithFailure("a done pulse appeared while rdy was held low");
            end
            if (gotLoad && lsuDone) begin
                stopWithFailure("lsuDone pulsed without an outstanding data request");
            end
            if (gotFetch && fetchDone) begin
                stopWithFailure("fetchDone pulsed without an outstanding fetch");
            end
            if (!gotLoad) begin
                if (lsuDone) begin
                    gotLoad = 1'b1;
                    loadAt  = cycle;
                    checkReady("lsuReady", lsuReady, 1'b1);
                    checkNick("respNick", respNick, rowNick[r]);
                    if (kind != rowStore) begin
                        checkData("rdData", rdData, expLoad);
                    end
                end else begin
                    checkReady("lsuReady", lsuReady, 1'b0);
                end
            end
            if (!gotFetch) begin
                if (fetchDone) begin
                    gotFetch = 1'b1;
                    fetchAt  = cycle;
                    checkReady("fetchReady", fetchReady, 1'b1);
                    checkData("fetchData", fetchData, expFetch);
                end else begin
                    checkReady("fetchReady", fetchReady, 1'b0);
                end
            end
            // The stall starts once the controller has taken the request.
            if (rowStall[r] > 0 && cycle == 2) begin
                rdy <= 1'b0;
            end
            if (rowStall[r] > 0 && cycle == 2 + rowStall[r]) begin
                rdy <= 1'b1;
            end
        end
        if (kind == rowBoth && loadAt > fetchAt) begin
            stopWithFailure("the load finished after the fetch issued in the same cycle");
        end
    endtask

    initial begin
        repeat (resetCycles + 2 + numRows * cyclesPerRow) @(posedge clk);
        stopWithFailure("timeout: the tests did not finish in the allowed number of cycles");
    end

    initial begin
        rst       = 1'b1;
        rdy       = 1'b1;
        fetchEn   = 1'b0;
        fetchAddr = '0;
        lsuEn     = 1'b0;
        lsuAccess = accLoad;
        lsuAddr   = '0;
        lsuData   = '0;
        lsuLen    = 3'd4;
        lsuNick   = '0;
        refMem    = '{default: 8'h00};
        lfsrState = 32'hc558_e4d2;
        buildTable();

        repeat (resetCycles) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);
        checkReady("fetchReady", fetchReady, 1'b1);
        checkReady("lsuReady", lsuReady, 1'b1);
        checkReady("fetchDone", fetchDone, 1'b0);
        checkReady("lsuDone", lsuDone, 1'b0);

        for (int r = 0; r < numRows; r++) begin
            runRow(rowBits'(r));
        end

        $display("Finished with no errors");
        $finish;
    end

endmodule

`default_nettype wire

/* tb.f */
common/memBusPkg.sv
common/lsuPkg.sv
fetch/fetchPort.sv
data/dataPort.sv
memctrl/byteRam.sv
memctrl/memController.sv
logic/memSubsystem.sv
test/memSubsystemTb.sv

/* run.sh */
#!/bin/sh
# Builds the testbench with Verilator, runs it and checks the result.

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing -f tb.f --top-module memSubsystemTb -Mdir obj_dir -o simv; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/simv 2>&1)
status=$?
printf '%s\n' "$output"

if [ "$status" -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qxF "Finished with no errors"; then
    exit 0
fi

echo "Pass line not found in the simulation output"
exit 1
